//--- hw/flowPkg.sv
// Flow count and width are fixed here; NumFlows must be at least 2 for the source index
package flowPkg;

  // --------------------
  // Flow shape
  // --------------------

  // Input flows merged by the multiplexer
  localparam int NumFlows = 4;

  // Data bits carried per flow
  localparam int Width = 8;

  // Payload of a single flow
  typedef logic [Width-1:0] flowData_t;

  // Beat held in the output register
  // Source field has the same width as arbPkg::IdxWidth
  typedef struct packed {
    flowData_t                   data;
    logic [$clog2(NumFlows)-1:0] src;
  } popBeat_t;

endpackage : flowPkg

//--- hw/arbPkg.sv
// Round-robin arbitration constants, derived from flowPkg::NumFlows
package arbPkg;

  // --------------------
  // Arbitration
  // --------------------

  // Bits needed to name one flow
  localparam int IdxWidth = $clog2(flowPkg::NumFlows);

  // Last grant loaded at reset
  // Pointing at the top flow makes flow 0 the first winner
  localparam int ResetLastGrant = flowPkg::NumFlows - 1;

endpackage : arbPkg

//--- hw/rrArbiter.sv
// Round-robin arbiter; grant is combinational and the priority moves only on enablePriorityUpdate
`timescale 1ns/1ps

module rrArbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [flowPkg::NumFlows-1:0]  request,
  input  logic                          enablePriorityUpdate,
  output logic [flowPkg::NumFlows-1:0]  grant
);

  // Index of the most recent winner
  logic [arbPkg::IdxWidth-1:0] lastGrant;
  // Index of the current winner, valid when anyWin is set
  logic [arbPkg::IdxWidth-1:0] winIdx;
  logic                        anyWin;

  // --------------------
  // Grant search
  // --------------------

  // Scan upward from the slot after the last grant, wrapping around
  always_comb begin
    int pos;
    grant  = '0;
    winIdx = lastGrant;
    anyWin = 1'b0;
    for (int k = 1; k <= flowPkg::NumFlows; k++) begin
      pos = (int'(lastGrant) + k) % flowPkg::NumFlows;
      // First requester found wins
      if (!anyWin && request[pos]) begin
        grant[pos] = 1'b1;
        winIdx     = pos[arbPkg::IdxWidth-1:0];
        anyWin     = 1'b1;
      end
    end
  end

  // --------------------
  // Priority state
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      lastGrant <= arbPkg::ResetLastGrant[arbPkg::IdxWidth-1:0];
    end else if (enablePriorityUpdate && anyWin) begin
      // Winner drops to lowest priority
      lastGrant <= winIdx;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // At most one winner, and only among requesters
  grantLegal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~request) == '0))
    else $error("rrArbiter: illegal grant %b for request %b", grant, request);

  // Work conserving
  grantWhenRequest: assert property (@(posedge clk) disable iff (rst)
    |request |-> |grant)
    else $error("rrArbiter: request %b left without grant", request);

endmodule : rrArbiter

//--- hw/flowArbCore.sv
// Ready-valid control around an external arbiter; pop valid is unstable until accepted
`timescale 1ns/1ps

module flowArbCore (
  input  logic                          clk,
  input  logic                          rst,
  // Arbiter side
  output logic [flowPkg::NumFlows-1:0]  request,
  input  logic [flowPkg::NumFlows-1:0]  grant,
  output logic                          enablePriorityUpdate,
  // Push side
  input  logic [flowPkg::NumFlows-1:0]  pushValid,
  output logic [flowPkg::NumFlows-1:0]  pushReady,
  // Pop side
  input  logic                          popReady,
  output logic                          popValidUnstable
);

  // --------------------
  // Flow control
  // --------------------

  // Every valid flow competes
  assign request = pushValid;

  // Any pending flow makes the pop side valid
  assign popValidUnstable = |pushValid;

  // Only the winner sees ready, and only when the pop side takes it
  assign pushReady = grant & {flowPkg::NumFlows{popReady}};

  // Priority rotates on a real pop transfer
  assign enablePriorityUpdate = popValidUnstable && popReady;

  // --------------------
  // Checks
  // --------------------

  // A stalled flow keeps its valid up until accepted
  for (genvar i = 0; i < flowPkg::NumFlows; i++) begin : genPushStable
    pushValidHeld: assert property (@(posedge clk) disable iff (rst)
      (pushValid[i] && !pushReady[i]) |=> pushValid[i])
      else $error("flowArbCore: flow %0d dropped valid before accept", i);
  end

endmodule : flowArbCore

//--- hw/onehotMux.sv
// One-hot selector; select must be one-hot or zero, zero select gives all-zero output
`timescale 1ns/1ps

module onehotMux #(
  parameter int  NumInputs = 2,
  parameter type PayloadT  = logic
) (
  input  logic                          clk,
  input  logic    [NumInputs-1:0]       select,
  input  PayloadT [NumInputs-1:0]       in,
  output PayloadT                       out
);

  // --------------------
  // Selection
  // --------------------

  // OR of the inputs masked by their select bit
  always_comb begin
    out = '0;
    for (int i = 0; i < NumInputs; i++) begin
      if (select[i]) begin
        out = out | in[i];
      end
    end
  end

  // More than one hot bit would blend payloads
  selectOnehot: assert property (@(posedge clk) $onehot0(select))
    else $error("onehotMux: select %b is not one-hot", select);

endmodule : onehotMux

//--- hw/flowMuxCore.sv
// Zero-latency flow mux; pop data and source may change until the pop side accepts
`timescale 1ns/1ps

module flowMuxCore (
  input  logic                                              clk,
  input  logic                                              rst,
  // Arbiter side
  output logic               [flowPkg::NumFlows-1:0]        request,
  input  logic               [flowPkg::NumFlows-1:0]        grant,
  output logic                                              enablePriorityUpdate,
  // Push side
  input  logic               [flowPkg::NumFlows-1:0]        pushValid,
  output logic               [flowPkg::NumFlows-1:0]        pushReady,
  input  flowPkg::flowData_t [flowPkg::NumFlows-1:0]        pushData,
  // Pop side
  input  logic                                              popReady,
  output logic                                              popValidUnstable,
  output flowPkg::flowData_t                                popDataUnstable,
  output logic               [arbPkg::IdxWidth-1:0]         popSrcUnstable
);

  // --------------------
  // Control and data path
  // --------------------

  flowArbCore arbCore (
    .clk                 (clk),
    .rst                 (rst),
    .request             (request),
    .grant               (grant),
    .enablePriorityUpdate(enablePriorityUpdate),
    .pushValid           (pushValid),
    .pushReady           (pushReady),
    .popReady            (popReady),
    .popValidUnstable    (popValidUnstable)
  );

  onehotMux #(
    .NumInputs(flowPkg::NumFlows),
    .PayloadT (flowPkg::flowData_t)
  ) dataMux (
    .clk   (clk),
    .select(grant),
    .in    (pushData),
    .out   (popDataUnstable)
  );

  // Grant to index, zero when nothing is granted
  always_comb begin
    popSrcUnstable = '0;
    for (int i = 0; i < flowPkg::NumFlows; i++) begin
      if (grant[i]) popSrcUnstable = i[arbPkg::IdxWidth-1:0];
    end
  end

  // Accepted flow is the one steered to the pop side
  for (genvar i = 0; i < flowPkg::NumFlows; i++) begin : genDataSelected
    dataSelected: assert property (@(posedge clk) disable iff (rst)
      (pushValid[i] && pushReady[i]) |->
        (popDataUnstable == pushData[i]) && (popSrcUnstable == i))
      else $error("flowMuxCore: flow %0d accepted but not steered", i);
  end

endmodule : flowMuxCore

//--- hw/flowRegForward.sv
// One-entry forward register; full throughput, popData stable under back-pressure
`timescale 1ns/1ps

module flowRegForward #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  // Upstream
  input  logic    pushValid,
  output logic    pushReady,
  input  PayloadT pushData,
  // Downstream
  output logic    popValid,
  input  logic    popReady,
  output PayloadT popData
);

  // --------------------
  // Register stage
  // --------------------

  // Room when empty or when the held beat leaves this cycle
  assign pushReady = !popValid || popReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      popValid <= 1'b0;
    end else if (pushReady) begin
      popValid <= pushValid;
    end
  end

  // Payload loads only on a push transfer
  always_ff @(posedge clk) begin
    if (pushValid && pushReady) begin
      popData <= pushData;
    end
  end

  // Held beat stays put until taken
  popHeld: assert property (@(posedge clk) disable iff (rst)
    (popValid && !popReady) |=> popValid && $stable(popData))
    else $error("flowRegForward: pop beat changed under back-pressure");

endmodule : flowRegForward

//--- hw/flowMux.sv
// Four-flow round-robin mux with a registered output; one cycle from push accept to pop
`timescale 1ns/1ps

module flowMux (
  input  logic                                        clk,
  input  logic                                        rst,
  // Input flows
  input  logic               [flowPkg::NumFlows-1:0]  pushValid,
  output logic               [flowPkg::NumFlows-1:0]  pushReady,
  input  flowPkg::flowData_t [flowPkg::NumFlows-1:0]  pushData,
  // Merged output
  output logic                                        popValid,
  input  logic                                        popReady,
  output flowPkg::flowData_t                          popData,
  output logic               [arbPkg::IdxWidth-1:0]   popSrc
);

  // Arbiter handshake
  logic [flowPkg::NumFlows-1:0] request;
  logic [flowPkg::NumFlows-1:0] grant;
  logic                         enablePriorityUpdate;

  // Unstable core output
  logic                         popValidUnstable;
  flowPkg::flowData_t           popDataUnstable;
  logic [arbPkg::IdxWidth-1:0]  popSrcUnstable;
  logic                         coreReady;

  // Beats around the output register
  flowPkg::popBeat_t            coreBeat;
  flowPkg::popBeat_t            outBeat;

  // --------------------
  // Arbitration
  // --------------------

  rrArbiter arbiter (
    .clk                 (clk),
    .rst                 (rst),
    .request             (request),
    .enablePriorityUpdate(enablePriorityUpdate),
    .grant               (grant)
  );

  flowMuxCore core (
    .clk                 (clk),
    .rst                 (rst),
    .request             (request),
    .grant               (grant),
    .enablePriorityUpdate(enablePriorityUpdate),
    .pushValid           (pushValid),
    .pushReady           (pushReady),
    .pushData            (pushData),
    .popReady            (coreReady),
    .popValidUnstable    (popValidUnstable),
    .popDataUnstable     (popDataUnstable),
    .popSrcUnstable      (popSrcUnstable)
  );

  // --------------------
  // Output stage
  // --------------------

  // Tag data with its source before registering
  assign coreBeat = '{data: popDataUnstable, src: popSrcUnstable};

  flowRegForward #(
    .PayloadT(flowPkg::popBeat_t)
  ) outReg (
    .clk      (clk),
    .rst      (rst),
    .pushValid(popValidUnstable),
    .pushReady(coreReady),
    .pushData (coreBeat),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (outBeat)
  );

  assign popData = outBeat.data;
  assign popSrc  = outBeat.src;

endmodule : flowMux

//--- bench/clockGen.sv
// Free-running testbench clock; starts low, first rising edge at half a period
`timescale 1ns/1ps

module clockGen #(
  parameter int Period = 100
) (
  output logic clk
);

  // Toggle every half period
  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

endmodule : clockGen

//--- bench/flowMuxTb.sv
// Table-driven flowMux testbench; expected values assume four flows of 8 bits and reset priority 3
`timescale 1ns/1ps

module flowMuxTb;

  localparam int ClkPeriod = 100;
  localparam int ResetCycles = 8;
  localparam int NumRows = 21;

  // One cycle of stimulus and the response it should give
  // pushData packs flow 3 in the top byte down to flow 0 in the low byte
  typedef struct packed {
    logic [3:0]  pushValid;
    logic [31:0] pushData;
    logic        popReady;
    logic [3:0]  expReady;
    logic        expValid;
    logic [7:0]  expData;
    logic [1:0]  expSrc;
  } stimRow_t;

  logic                                        clk;
  logic                                        rst;
  logic               [flowPkg::NumFlows-1:0]  pushValid;
  logic               [flowPkg::NumFlows-1:0]  pushReady;
  flowPkg::flowData_t [flowPkg::NumFlows-1:0]  pushData;
  logic                                        popValid;
  logic                                        popReady;
  flowPkg::flowData_t                          popData;
  logic               [arbPkg::IdxWidth-1:0]   popSrc;
  int                                          curRow;

  // --------------------
  // Stimulus table
  // --------------------

  // pushReady is seen before the edge, pop outputs after it
  stimRow_t stimTable [NumRows] = '{
    // Idle after reset
    '{4'b0000, 32'h00000000, 1'b1, 4'b0000, 1'b0, 8'h00, 2'd0},
    // All four busy, rotation 0 1 2 3 0 with no bubbles
    // Reset priority makes flow 0 the first winner
    '{4'b1111, 32'h70605040, 1'b1, 4'b0001, 1'b1, 8'h40, 2'd0},
    '{4'b1111, 32'h70605041, 1'b1, 4'b0010, 1'b1, 8'h50, 2'd1},
    '{4'b1111, 32'h70605141, 1'b1, 4'b0100, 1'b1, 8'h60, 2'd2},
    '{4'b1111, 32'h70615141, 1'b1, 4'b1000, 1'b1, 8'h70, 2'd3},
    '{4'b1111, 32'h71615141, 1'b1, 4'b0001, 1'b1, 8'h41, 2'd0},
    // Back-pressure holds the beat and the priority
    '{4'b1111, 32'h71615142, 1'b0, 4'b0000, 1'b1, 8'h41, 2'd0},
    '{4'b1111, 32'h71615142, 1'b0, 4'b0000, 1'b1, 8'h41, 2'd0},
    // Released, resumes at flow 1
    '{4'b1111, 32'h71615142, 1'b1, 4'b0010, 1'b1, 8'h51, 2'd1},
    '{4'b1101, 32'h71610042, 1'b1, 4'b0100, 1'b1, 8'h61, 2'd2},
    '{4'b1001, 32'h71000042, 1'b1, 4'b1000, 1'b1, 8'h71, 2'd3},
    '{4'b0001, 32'h00000042, 1'b1, 4'b0001, 1'b1, 8'h42, 2'd0},
    '{4'b0000, 32'h00000000, 1'b1, 4'b0000, 1'b0, 8'h00, 2'd0},
    // Lone beat on flow 3, then drained
    '{4'b1000, 32'h31000000, 1'b1, 4'b1000, 1'b1, 8'h31, 2'd3},
    '{4'b0000, 32'h00000000, 1'b1, 4'b0000, 1'b0, 8'h00, 2'd0},
    // Flow 1 fills the register, flow 0 waits, flow 2 arrives later
    '{4'b0010, 32'h00005200, 1'b0, 4'b0010, 1'b1, 8'h52, 2'd1},
    '{4'b0001, 32'h00000043, 1'b0, 4'b0000, 1'b1, 8'h52, 2'd1},
    '{4'b0101, 32'h00620043, 1'b0, 4'b0000, 1'b1, 8'h52, 2'd1},
    // Flow 2 is next after flow 1, so it passes flow 0
    '{4'b0101, 32'h00620043, 1'b1, 4'b0100, 1'b1, 8'h62, 2'd2},
    '{4'b0001, 32'h00000043, 1'b1, 4'b0001, 1'b1, 8'h43, 2'd0},
    '{4'b0000, 32'h00000000, 1'b1, 4'b0000, 1'b0, 8'h00, 2'd0}
  };

  // --------------------
  // DUT and clock
  // --------------------

  clockGen #(.Period(ClkPeriod)) clkGen (.clk(clk));

  flowMux uut (
    .clk      (clk),
    .rst      (rst),
    .pushValid(pushValid),
    .pushReady(pushReady),
    .pushData (pushData),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData),
    .popSrc   (popSrc)
  );

  // Stops at the first mismatch
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR: row %0d %s expected 0x%0h actual 0x%0h",
               curRow, name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // --------------------
  // Sequence
  // --------------------

  initial begin
    rst       = 1'b1;
    pushValid = '0;
    pushData  = '0;
    popReady  = 1'b0;
    curRow    = -1;
    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;
    // Nothing valid or ready straight out of reset
    checkValue("popValid", 32'(1'b0), 32'(popValid));
    checkValue("pushReady", 32'(4'b0000), 32'(pushReady));
    for (int r = 0; r < NumRows; r++) begin
      curRow    = r;
      pushValid = stimTable[r].pushValid;
      pushData  = stimTable[r].pushData;
      popReady  = stimTable[r].popReady;
      // Combinational ready settles within the low phase
      #1;
      checkValue("pushReady", 32'(stimTable[r].expReady), 32'(pushReady));
      @(negedge clk);
      checkValue("popValid", 32'(stimTable[r].expValid), 32'(popValid));
      if (stimTable[r].expValid) begin
        checkValue("popData", 32'(stimTable[r].expData), 32'(popData));
        checkValue("popSrc", 32'(stimTable[r].expSrc), 32'(popSrc));
      end
    end
    $display("** PASS **");
    $finish;
  end

  // Reset plus table plus margin
  initial begin
    #((NumRows + ResetCycles + 20) * ClkPeriod);
    $display("Timeout: the stimulus table did not finish in the allowed time");
    $display("** FAIL **");
    $fatal(1, "Watchdog expired");
  end

endmodule : flowMuxTb

//--- project.f
hw/flowPkg.sv
hw/arbPkg.sv
hw/rrArbiter.sv
hw/flowArbCore.sv
hw/onehotMux.sv
hw/flowMuxCore.sv
hw/flowRegForward.sv
hw/flowMux.sv
bench/clockGen.sv
bench/flowMuxTb.sv

//--- run.sh
#!/bin/sh
# Builds the flowMux testbench with Verilator and runs it
# Exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module flowMuxTb --Mdir obj_dir -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/VflowMuxTb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
